// ==== source/rv_isa_pkg.sv ====
package rv_isa_pkg;

  // Instruction field types
  typedef logic [6:0] opcode_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // --------------------
  // Major opcodes
  // --------------------
  localparam opcode_t op_lui    = 7'b0110111;
  localparam opcode_t op_jal    = 7'b1101111;
  localparam opcode_t op_branch = 7'b1100011;
  localparam opcode_t op_load   = 7'b0000011;
  localparam opcode_t op_store  = 7'b0100011;
  localparam opcode_t op_imm    = 7'b0010011;
  localparam opcode_t op_reg    = 7'b0110011;
  localparam opcode_t op_system = 7'b1110011;

  // --------------------
  // funct3 codes
  // --------------------
  // Branch conditions
  localparam funct3_t f3_beq = 3'b000;
  localparam funct3_t f3_bne = 3'b001;
  // ALU, same codes for OP and OP-IMM
  localparam funct3_t f3_add = 3'b000;
  localparam funct3_t f3_sll = 3'b001;
  localparam funct3_t f3_slt = 3'b010;
  localparam funct3_t f3_xor = 3'b100;
  localparam funct3_t f3_srl = 3'b101;
  localparam funct3_t f3_or  = 3'b110;
  localparam funct3_t f3_and = 3'b111;
  // Word width, used by both LW and SW
  localparam funct3_t f3_lw  = 3'b010;

  // --------------------
  // funct7 codes
  // --------------------
  localparam funct7_t f7_base = 7'b0000000;
  // Selects SUB over ADD
  localparam funct7_t f7_alt  = 7'b0100000;

  // Full EBREAK word, every field fixed
  localparam logic [31:0] instr_ebreak = 32'h0010_0073;

endpackage

// ==== source/rv_core_pkg.sv ====
package rv_core_pkg;

  // Machine word, also used for addresses and PCs
  typedef logic [31:0] word_t;

  // --------------------
  // ALU operations
  // --------------------
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_slt,
    // Operand B straight through, for LUI
    alu_pass_b
  } alu_op_e;

  // Write-back source
  typedef enum logic [1:0] {
    res_alu,
    res_mem,
    res_pc4
  } res_src_e;

  // Next PC choice from execute to fetch
  typedef enum logic [1:0] {
    pc_seq,
    pc_target,
    pc_hold
  } next_pc_e;

endpackage

// ==== source/rv_fetch.sv ====
`timescale 1ns/1ns

module rv_fetch
  import rv_core_pkg::*;
#(
  parameter word_t RESET_PC = '0
) (
  input  logic     clk,
  input  logic     rst_n,
  input  next_pc_e next_pc,
  input  word_t    target,
  input  logic     halt_req,
  output word_t    pc,
  output logic     halted,
  output logic     fetch_en
);

  // --------------------
  // PC and halt state
  // --------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc     <= RESET_PC;
      halted <= 1'b0;
    end else begin
      // Sticky until the next reset
      if (halt_req) begin
        halted <= 1'b1;
      end
      // Frozen once halted, whatever the memory returns
      if (!halted) begin
        case (next_pc)
          pc_seq:    pc <= pc + 32'd4;
          pc_target: pc <= target;
          default:   pc <= pc;
        endcase
      end
    end
  end

  assign fetch_en = !halted;

  // Targets from execute keep word alignment
  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00);

endmodule

// ==== source/rv_decode.sv ====
`timescale 1ns/1ns

module rv_decode
  import rv_isa_pkg::*;
  import rv_core_pkg::*;
(
  input  word_t    instr,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output reg_idx_t rd,
  output word_t    imm,
  output alu_op_e  alu_op,
  output logic     alu_b_imm,
  output logic     reg_write,
  output logic     mem_read,
  output logic     mem_write,
  output logic     is_branch,
  output logic     branch_ne,
  output logic     is_jal,
  output logic     is_ebreak,
  output logic     illegal,
  output res_src_e res_src
);

  opcode_t opcode;
  funct3_t funct3;
  funct7_t funct7;
  word_t   imm_i;
  word_t   imm_s;
  word_t   imm_b;
  word_t   imm_j;
  word_t   imm_u;
  alu_op_e alu_f3;
  logic    f3_ok;
  logic    is_shift;
  logic    write_rd;

  // Fixed field positions
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rd     = instr[11:7];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  // --------------------
  // Immediate formats
  // --------------------
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};

  // funct3 to ALU op, shared by OP and OP-IMM
  always_comb begin
    f3_ok = 1'b1;
    case (funct3)
      f3_add:  alu_f3 = alu_add;
      f3_sll:  alu_f3 = alu_sll;
      f3_slt:  alu_f3 = alu_slt;
      f3_xor:  alu_f3 = alu_xor;
      f3_srl:  alu_f3 = alu_srl;
      f3_or:   alu_f3 = alu_or;
      f3_and:  alu_f3 = alu_and;
      // SLTU is outside the subset
      default: begin
        alu_f3 = alu_add;
        f3_ok  = 1'b0;
      end
    endcase
  end

  assign is_shift = (funct3 == f3_sll) || (funct3 == f3_srl);

  // --------------------
  // Control
  // --------------------
  always_comb begin
    imm       = '0;
    alu_op    = alu_add;
    alu_b_imm = 1'b0;
    write_rd  = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    is_branch = 1'b0;
    branch_ne = 1'b0;
    is_jal    = 1'b0;
    is_ebreak = 1'b0;
    illegal   = 1'b0;
    res_src   = res_alu;
    case (opcode)
      op_lui: begin
        imm       = imm_u;
        alu_op    = alu_pass_b;
        alu_b_imm = 1'b1;
        write_rd  = 1'b1;
      end
      op_jal: begin
        // Link value comes from the pc+4 path
        imm      = imm_j;
        is_jal   = 1'b1;
        write_rd = 1'b1;
        res_src  = res_pc4;
      end
      op_branch: begin
        imm = imm_b;
        if (funct3 == f3_beq || funct3 == f3_bne) begin
          is_branch = 1'b1;
          branch_ne = (funct3 == f3_bne);
        end else begin
          illegal = 1'b1;
        end
      end
      op_load: begin
        // Address is rs1 + imm through the ALU
        imm       = imm_i;
        alu_b_imm = 1'b1;
        mem_read  = (funct3 == f3_lw);
        write_rd  = (funct3 == f3_lw);
        res_src   = res_mem;
        illegal   = (funct3 != f3_lw);
      end
      op_store: begin
        imm       = imm_s;
        alu_b_imm = 1'b1;
        mem_write = (funct3 == f3_lw);
        illegal   = (funct3 != f3_lw);
      end
      op_imm: begin
        imm       = imm_i;
        alu_op    = alu_f3;
        alu_b_imm = 1'b1;
        write_rd  = 1'b1;
        // shamt shares imm[4:0], upper bits must be zero (no SRAI)
        illegal   = !f3_ok || (is_shift && funct7 != f7_base);
      end
      op_reg: begin
        write_rd = 1'b1;
        if (funct7 == f7_alt && funct3 == f3_add) begin
          alu_op = alu_sub;
        end else begin
          alu_op  = alu_f3;
          illegal = !f3_ok || (funct7 != f7_base);
        end
      end
      op_system: begin
        // ECALL and CSR ops trap
        is_ebreak = (instr == instr_ebreak);
        illegal   = (instr != instr_ebreak);
      end
      default: illegal = 1'b1;
    endcase
  end

  // No write for x0 or for anything that traps
  assign reg_write = write_rd && !illegal && (rd != '0);

endmodule

// ==== source/rv_regfile.sv ====
`timescale 1ns/1ns

module rv_regfile
  import rv_isa_pkg::*;
  import rv_core_pkg::*;
(
  input  logic     clk,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  reg_idx_t rd,
  input  word_t    rd_data,
  input  logic     reg_write,
  output word_t    rs1_data,
  output word_t    rs2_data
);

  // x1..x31 only, x0 has no storage
  word_t regs [1:31];

  // Write lands at the edge
  always_ff @(posedge clk) begin
    if (reg_write && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  // --------------------
  // Read ports
  // --------------------
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  // Decode already drops writes to x0
  a_no_x0_write: assert property (@(posedge clk) reg_write |-> rd != '0);

endmodule

// ==== source/rv_execute.sv ====
`timescale 1ns/1ns

module rv_execute
  import rv_core_pkg::*;
(
  input  word_t    pc,
  input  word_t    rs1_data,
  input  word_t    rs2_data,
  input  word_t    imm,
  input  alu_op_e  alu_op,
  input  logic     alu_b_imm,
  input  logic     is_branch,
  input  logic     branch_ne,
  input  logic     is_jal,
  input  logic     halt_req,
  output word_t    alu_result,
  output word_t    target,
  output next_pc_e next_pc
);

  word_t alu_b;
  logic  operands_eq;
  logic  branch_taken;

  // Operand B from register or immediate
  assign alu_b = alu_b_imm ? imm : rs2_data;

  // --------------------
  // ALU
  // --------------------
  always_comb begin
    case (alu_op)
      alu_add:    alu_result = rs1_data + alu_b;
      alu_sub:    alu_result = rs1_data - alu_b;
      alu_and:    alu_result = rs1_data & alu_b;
      alu_or:     alu_result = rs1_data | alu_b;
      alu_xor:    alu_result = rs1_data ^ alu_b;
      // Shift amount is the low five bits
      alu_sll:    alu_result = rs1_data << alu_b[4:0];
      alu_srl:    alu_result = rs1_data >> alu_b[4:0];
      alu_slt:    alu_result = {31'b0, $signed(rs1_data) < $signed(alu_b)};
      alu_pass_b: alu_result = alu_b;
      default:    alu_result = '0;
    endcase
  end

  // --------------------
  // Branch and jump
  // --------------------
  // Compare always uses rs2, never the immediate
  assign operands_eq  = (rs1_data == rs2_data);
  assign branch_taken = is_branch && (branch_ne ? !operands_eq : operands_eq);

  // Shared target adder for JAL and branches
  assign target = pc + imm;

  // Halt wins over any redirect
  always_comb begin
    if (halt_req) begin
      next_pc = pc_hold;
    end else if (is_jal || branch_taken) begin
      next_pc = pc_target;
    end else begin
      next_pc = pc_seq;
    end
  end

endmodule

// ==== source/rv_core.sv ====
`timescale 1ns/1ns

module rv_core
  import rv_isa_pkg::*;
  import rv_core_pkg::*;
#(
  parameter word_t RESET_PC = '0
) (
  input  logic       clk,
  input  logic       rst_n,
  // Instruction memory, read only
  output logic       imem_ren,
  output word_t      imem_raddr,
  input  word_t      imem_rdata,
  // Data memory read
  output logic       dmem_ren,
  output word_t      dmem_raddr,
  input  word_t      dmem_rdata,
  // Data memory write
  output logic       dmem_we,
  output word_t      dmem_waddr,
  output word_t      dmem_wdata,
  output logic [3:0] dmem_wstrb,
  // Sticky halt causes
  output logic       ebreak,
  output logic       trap
);

  word_t    pc;
  word_t    pc_plus4;
  logic     halted;
  logic     fetch_en;
  logic     halt_req;
  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  word_t    imm;
  alu_op_e  alu_op;
  logic     alu_b_imm;
  logic     reg_write;
  logic     mem_read;
  logic     mem_write;
  logic     is_branch;
  logic     branch_ne;
  logic     is_jal;
  logic     is_ebreak;
  logic     illegal;
  res_src_e res_src;
  word_t    rs1_data;
  word_t    rs2_data;
  word_t    rd_data;
  word_t    alu_result;
  word_t    target;
  next_pc_e next_pc;

  // --------------------
  // Datapath blocks
  // --------------------
  rv_fetch #(
    .RESET_PC(RESET_PC)
  ) fetch_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .next_pc (next_pc),
    .target  (target),
    .halt_req(halt_req),
    .pc      (pc),
    .halted  (halted),
    .fetch_en(fetch_en)
  );

  rv_decode decode_i (
    .instr    (imem_rdata),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .imm      (imm),
    .alu_op   (alu_op),
    .alu_b_imm(alu_b_imm),
    .reg_write(reg_write),
    .mem_read (mem_read),
    .mem_write(mem_write),
    .is_branch(is_branch),
    .branch_ne(branch_ne),
    .is_jal   (is_jal),
    .is_ebreak(is_ebreak),
    .illegal  (illegal),
    .res_src  (res_src)
  );

  // Halted core writes nothing back
  rv_regfile regfile_i (
    .clk      (clk),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .rd_data  (rd_data),
    .reg_write(reg_write && fetch_en),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_execute execute_i (
    .pc        (pc),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .imm       (imm),
    .alu_op    (alu_op),
    .alu_b_imm (alu_b_imm),
    .is_branch (is_branch),
    .branch_ne (branch_ne),
    .is_jal    (is_jal),
    .halt_req  (halt_req),
    .alu_result(alu_result),
    .target    (target),
    .next_pc   (next_pc)
  );

  assign halt_req = is_ebreak || illegal;
  assign pc_plus4 = pc + 32'd4;

  // Write-back select
  always_comb begin
    case (res_src)
      res_mem: rd_data = dmem_rdata;
      res_pc4: rd_data = pc_plus4;
      default: rd_data = alu_result;
    endcase
  end

  // --------------------
  // Memory ports
  // --------------------
  assign imem_ren   = fetch_en;
  assign imem_raddr = pc;

  // Loads and stores share the ALU address
  assign dmem_ren   = mem_read && fetch_en;
  assign dmem_raddr = alu_result;
  assign dmem_we    = mem_write && fetch_en;
  assign dmem_waddr = alu_result;
  assign dmem_wdata = rs2_data;
  // word stores only
  assign dmem_wstrb = {4{dmem_we}};

  // Halt cause, caught on the first halting cycle only
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ebreak <= 1'b0;
      trap   <= 1'b0;
    end else begin
      ebreak <= ebreak || (is_ebreak && !halted);
      trap   <= trap || (illegal && !halted);
    end
  end

  // One instruction is never both a load and a store
  a_mem_exclusive: assert property (@(posedge clk) disable iff (!rst_n) !(dmem_we && dmem_ren));

endmodule

// ==== bench/rv_clock_gen.sv ====
`timescale 1ns/1ns

module rv_clock_gen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic rst_n
);

  // Free running clock
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Power-on reset, released on a rising edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// ==== bench/rv_checker.sv ====
`timescale 1ns/1ns

module rv_checker
  import rv_core_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input logic       imem_ren,
  input logic       dmem_ren,
  input logic       dmem_we,
  input word_t      dmem_waddr,
  input word_t      dmem_wdata,
  input logic [3:0] dmem_wstrb,
  input logic       ebreak,
  input logic       trap
);

  string      test_name = "none";
  logic       store_seen = 1'b0;
  logic       rst_q = 1'b0;
  word_t      last_addr;
  word_t      last_data;
  logic [3:0] last_strb;
  int         mismatch_errors = 0;
  int         event_errors = 0;
  int         late_store_errors = 0;
  int         halted_strobe_errors = 0;
  int         timeout_errors = 0;

  // --------------------
  // Store monitor
  // --------------------
  // Sampled on the edge that commits the store
  always @(posedge clk) begin
    if (!rst_n) begin
      store_seen <= 1'b0;
    end else if (dmem_we) begin
      store_seen <= 1'b1;
      last_addr  <= dmem_waddr;
      last_data  <= dmem_wdata;
      last_strb  <= dmem_wstrb;
      // Halted core must stay off the bus
      if (ebreak || trap) begin
        $display("ERROR test %s: store to %h seen after the core halted", test_name, dmem_waddr);
        late_store_errors <= late_store_errors + 1;
      end
    end
  end

  // --------------------
  // Strobes around reset and halt
  // --------------------
  always @(posedge clk) begin
    rst_q <= rst_n;
    // First cycle out of reset fetches with both halt flags clear
    if (rst_n && !rst_q) begin
      if (imem_ren !== 1'b1) begin
        $display("CHECK FAILED test %s imem_ren after reset: expected 1 actual %b", test_name,
                 imem_ren);
        mismatch_errors++;
      end
      if ({ebreak, trap} !== 2'b00) begin
        $display("CHECK FAILED test %s halt {ebreak,trap} after reset: expected 00 actual %b",
                 test_name, {ebreak, trap});
        mismatch_errors++;
      end
    end
    // Fetch and load strobes stay low once halted
    if (rst_n && (ebreak || trap) && (imem_ren || dmem_ren)) begin
      $display("ERROR test %s: fetch or load strobe seen after the core halted", test_name);
      halted_strobe_errors <= halted_strobe_errors + 1;
    end
  end

  // --------------------
  // Checks called per test
  // --------------------
  task automatic start_test(input string name);
    test_name = name;
  endtask

  task automatic compare_word(input string what, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("CHECK FAILED test %s %s: expected %h actual %h", test_name, what, expected,
               actual);
      mismatch_errors++;
    end
  endtask

  task automatic check_test(input word_t exp_addr, input word_t exp_data, input logic exp_trap);
    logic [1:0] exp_kind;
    // Halt kind as {ebreak, trap}
    exp_kind = exp_trap ? 2'b01 : 2'b10;
    if (!ebreak && !trap) begin
      $display("ERROR test %s: no halt, neither ebreak nor trap came up", test_name);
      event_errors++;
    end else if ({ebreak, trap} !== exp_kind) begin
      $display("CHECK FAILED test %s halt {ebreak,trap}: expected %b actual %b", test_name,
               exp_kind, {ebreak, trap});
      mismatch_errors++;
    end
    if (!store_seen) begin
      $display("ERROR test %s: no store seen, one to %h was expected", test_name, exp_addr);
      event_errors++;
    end else begin
      compare_word("store address", exp_addr, last_addr);
      compare_word("store data", exp_data, last_data);
      // Word stores drive all four byte lanes
      compare_word("store strobe", 32'hF, {28'b0, last_strb});
    end
  endtask

  task automatic note_timeout(input int cycles);
    $display("ERROR: run stopped by the timeout after %0d cycles", cycles);
    timeout_errors++;
  endtask

  function automatic int value_count();
    return mismatch_errors;
  endfunction

  function automatic int other_count();
    return event_errors + late_store_errors + halted_strobe_errors + timeout_errors;
  endfunction

endmodule

// ==== bench/rv_core_tb.sv ====
`timescale 1ns/1ns

module rv_core_tb
  import rv_core_pkg::*;
();

  localparam int NUM_TESTS   = 6;
  localparam int PROG_WORDS  = 12;
  localparam int IMEM_WORDS  = 16;
  localparam int DMEM_WORDS  = 64;
  // Per-test budget covers reset, the program and the quiet cycles after halt
  localparam int TEST_CYCLES = 64;
  localparam int CYCLE_LIMIT = NUM_TESTS * TEST_CYCLES;
  localparam int HALT_WAIT   = 48;

  logic       clk;
  logic       por_n;
  logic       test_rst_n;
  logic       rst_n;
  logic       imem_ren;
  word_t      imem_raddr;
  word_t      imem_rdata;
  logic       dmem_ren;
  word_t      dmem_raddr;
  word_t      dmem_rdata;
  logic       dmem_we;
  word_t      dmem_waddr;
  word_t      dmem_wdata;
  logic [3:0] dmem_wstrb;
  logic       ebreak;
  logic       trap;

  // Memory models and a copy of the initial data contents
  word_t imem [IMEM_WORDS];
  word_t dmem [DMEM_WORDS];
  word_t dmem_ref [DMEM_WORDS];

  // --------------------
  // Test table
  // --------------------
  string row_name [NUM_TESTS];
  word_t row_prog [NUM_TESTS][PROG_WORDS];
  word_t row_addr [NUM_TESTS];
  word_t row_data [NUM_TESTS];
  logic  row_trap [NUM_TESTS];
  int    row_count = 0;
  int    word_count = 0;
  int    cycle_count = 0;
  word_t seed_word;
  logic  halt_seen;

  assign rst_n = por_n && test_rst_n;

  rv_clock_gen #(
    .PERIOD_NS   (4),
    .RESET_CYCLES(2)
  ) clock_i (
    .clk  (clk),
    .rst_n(por_n)
  );

  rv_core #(
    .RESET_PC(32'h0)
  ) dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_ren  (imem_ren),
    .imem_raddr(imem_raddr),
    .imem_rdata(imem_rdata),
    .dmem_ren  (dmem_ren),
    .dmem_raddr(dmem_raddr),
    .dmem_rdata(dmem_rdata),
    .dmem_we   (dmem_we),
    .dmem_waddr(dmem_waddr),
    .dmem_wdata(dmem_wdata),
    .dmem_wstrb(dmem_wstrb),
    .ebreak    (ebreak),
    .trap      (trap)
  );

  rv_checker checker_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_ren  (imem_ren),
    .dmem_ren  (dmem_ren),
    .dmem_we   (dmem_we),
    .dmem_waddr(dmem_waddr),
    .dmem_wdata(dmem_wdata),
    .dmem_wstrb(dmem_wstrb),
    .ebreak    (ebreak),
    .trap      (trap)
  );

  // Zero-latency memories
  assign imem_rdata = imem[imem_raddr[5:2]];
  // Data comes back only under the load strobe
  assign dmem_rdata = dmem_ren ? dmem[dmem_raddr[7:2]] : '0;

  always @(posedge clk) begin
    if (dmem_we) begin
      dmem[dmem_waddr[7:2]] <= dmem_wdata;
    end
  end

  // Undefined opcode tagged with its slot so a runaway PC traps
  function automatic word_t filler_word(input int slot);
    return {slot[24:0], 7'h7F};
  endfunction

  task automatic begin_row(input string name, input word_t addr, input word_t data,
                           input logic want_trap);
    int i;
    row_name[row_count] = name;
    row_addr[row_count] = addr;
    row_data[row_count] = data;
    row_trap[row_count] = want_trap;
    for (i = 0; i < PROG_WORDS; i++) begin
      row_prog[row_count][i] = filler_word(i);
    end
    word_count = 0;
    row_count++;
  endtask

  task automatic put_word(input word_t instr);
    row_prog[row_count - 1][word_count] = instr;
    word_count++;
  endtask

  task automatic build_table();
    // x10 = ((((6 << 5) + 7) ^ 5) | 1) & -7, then >> 1
    begin_row("alu", 32'h40, 32'h60, 1'b0);
    put_word(32'hFF90_0093);  // addi x1, x0, -7
    put_word(32'h0050_0113);  // addi x2, x0, 5
    put_word(32'h0020_A1B3);  // slt  x3, x1, x2
    put_word(32'h0031_0233);  // add  x4, x2, x3
    put_word(32'h0022_12B3);  // sll  x5, x4, x2
    put_word(32'h4012_8333);  // sub  x6, x5, x1
    put_word(32'h0023_43B3);  // xor  x7, x6, x2
    put_word(32'h0033_E433);  // or   x8, x7, x3
    put_word(32'h0014_74B3);  // and  x9, x8, x1
    put_word(32'h0014_D513);  // srli x10, x9, 1
    put_word(32'h04A0_2023);  // sw   x10, 0x40(x0)
    put_word(32'h0010_0073);  // ebreak
    // Upper immediate plus sign-extended -16
    begin_row("lui_sext", 32'h40, 32'h1234_5000 + 32'hFFFF_FFF0, 1'b0);
    put_word(32'h1234_50B7);  // lui  x1, 0x12345
    put_word(32'hFF00_8093);  // addi x1, x1, -16
    put_word(32'h0410_2023);  // sw   x1, 0x40(x0)
    put_word(32'h0010_0073);  // ebreak
    // Sum 1..5 then a beq that falls through into the store
    begin_row("branch", 32'h40, 32'd15, 1'b0);
    put_word(32'h0000_0093);  // addi x1, x0, 0
    put_word(32'h0000_0113);  // addi x2, x0, 0
    put_word(32'h0050_0193);  // addi x3, x0, 5
    put_word(32'h0010_8093);  // addi x1, x1, 1
    put_word(32'h0011_0133);  // add  x2, x2, x1
    put_word(32'hFE30_9CE3);  // bne  x1, x3, -8
    put_word(32'h0020_8463);  // beq  x1, x2, +8
    put_word(32'h0420_2023);  // sw   x2, 0x40(x0)
    put_word(32'h0010_0073);  // ebreak
    // Link 0x04 + 4 plus the untouched counter 0x70
    begin_row("jal", 32'h44, 32'h08 + 32'h70, 1'b0);
    put_word(32'h0700_0113);  // addi x2, x0, 0x70
    put_word(32'h00C0_00EF);  // jal  x1, +12
    put_word(32'h0011_0113);  // addi x2, x2, 1
    put_word(32'h0011_0113);  // addi x2, x2, 1
    put_word(32'h0410_2023);  // sw   x1, 0x40(x0)
    put_word(32'h0020_8233);  // add  x4, x1, x2
    put_word(32'h0440_2223);  // sw   x4, 0x44(x0)
    put_word(32'h0010_0073);  // ebreak
    // Seeded word at 0x80 plus the reloaded value plus one
    begin_row("load_store", 32'h50, dmem_ref[32] + 32'hABCD_E001, 1'b0);
    put_word(32'hABCD_E0B7);  // lui  x1, 0xABCDE
    put_word(32'h0410_2423);  // sw   x1, 0x48(x0)
    put_word(32'h0480_2103);  // lw   x2, 0x48(x0)
    put_word(32'h0011_0113);  // addi x2, x2, 1
    put_word(32'h0420_2623);  // sw   x2, 0x4c(x0)
    put_word(32'h0800_2183);  // lw   x3, 0x80(x0)
    put_word(32'h0021_8233);  // add  x4, x3, x2
    put_word(32'h0440_2823);  // sw   x4, 0x50(x0)
    put_word(32'h0010_0073);  // ebreak
    // Only the first store may land
    begin_row("illegal", 32'h40, 32'h5A, 1'b1);
    put_word(32'h05A0_0093);  // addi x1, x0, 0x5a
    put_word(32'h0410_2023);  // sw   x1, 0x40(x0)
    put_word(32'hFFFF_FFFF);  // undefined opcode
    put_word(32'h0410_2223);  // sw   x1, 0x44(x0)
    put_word(32'h0010_0073);  // ebreak
  endtask

  task automatic load_program(input int t);
    int i;
    for (i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = (i < PROG_WORDS) ? row_prog[t][i] : filler_word(i);
    end
  endtask

  task automatic wait_for_halt(output logic seen);
    int n;
    seen = 1'b0;
    n = 0;
    while (!seen && n < HALT_WAIT) begin
      @(posedge clk);
      seen = ebreak || trap;
      n++;
    end
  endtask

  // --------------------
  // Watchdog
  // --------------------
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > CYCLE_LIMIT) begin
      checker_i.note_timeout(cycle_count);
      $display("errors: %0d value mismatches, %0d other failures", checker_i.value_count(),
               checker_i.other_count());
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin
    int i;
    int t;
    test_rst_n = 1'b1;
    seed_word = $urandom(86698);
    for (i = 0; i < DMEM_WORDS; i++) begin
      seed_word   = $urandom();
      dmem_ref[i] = seed_word;
      dmem[i]    <= seed_word;
    end
    for (i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = filler_word(i);
    end
    build_table();
    for (t = 0; t < row_count; t++) begin
      // Core is still halted here and ignores the new program until reset
      @(posedge clk);
      test_rst_n <= 1'b0;
      load_program(t);
      checker_i.start_test(row_name[t]);
      repeat (2) @(posedge clk);
      test_rst_n <= 1'b1;
      wait_for_halt(halt_seen);
      // Quiet cycles where a late store would show up
      if (halt_seen) begin
        repeat (2) @(posedge clk);
      end
      checker_i.check_test(row_addr[t], row_data[t], row_trap[t]);
    end
    $display("errors: %0d value mismatches, %0d other failures", checker_i.value_count(),
             checker_i.other_count());
    if (checker_i.value_count() + checker_i.other_count() == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
source/rv_isa_pkg.sv
source/rv_core_pkg.sv
source/rv_fetch.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_execute.sv
source/rv_core.sv
bench/rv_clock_gen.sv
bench/rv_checker.sv
bench/rv_core_tb.sv

// ==== Makefile ====
SRCS := $(wildcard source/*.sv bench/*.sv)
SIM  := obj_dir/Vrv_core_tb

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

$(SIM): $(SRCS) compile.f
	verilator --binary --timing --assert --timescale 1ns/1ns \
		-f compile.f --top-module rv_core_tb -Mdir obj_dir

clean:
	rm -rf obj_dir
